//--- project.f
+incdir+source
+incdir+test
source/isaPkg.sv
source/pipePkg.sv
source/pipeStageReg.sv
source/pipelineControl.sv
source/fetchUnit.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memoryUnit.sv
source/cpuCore.sv
test/cpuCoreTb.sv

//--- source/core_params.svh
// Core sizing macros shared by the packages and the RTL
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural register file
`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_W 5

`define CORE_OPCODE_W 6

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- source/cpuCore.sv
// Five-stage in-order core top level
module cpuCore import isaPkg::*; import pipePkg::*; (
	input logic clk,
	input logic rst_n,
	input wordT instrData,
	input logic instrReady,
	input wordT readData,
	input logic dataReady,
	output instrReqT instrReq,
	output dataReqT dataReq,
	output logic halt
);

	instrT decodeInstr;
	idExT decoded;
	idExT exStage;
	exMemT executed;
	exMemT memStage;
	memWbT completed;
	memWbT wbStage;
	fwdSelT fwdSelRs;
	fwdSelT fwdSelRt;
	logic pcHold;
	logic ifIdHold;
	logic ifIdBubble;
	logic idExEnable;
	logic idExClear;
	logic exMemEnable;
	logic memWbEnable;

	fetchUnit fetchUnit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pcHold(pcHold),
		.ifIdHold(ifIdHold),
		.ifIdBubble(ifIdBubble),
		.instrData(instrData),
		.instrReady(instrReady),
		.instrReq(instrReq),
		.decodeInstr(decodeInstr)
	);

	decodeUnit decodeUnit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.decodeInstr(decodeInstr),
		.wbStage(wbStage),
		.decoded(decoded)
	);

	pipeStageReg #(.payloadT(idExT)) idExReg_inst (
		.clk(clk),
		.rst_n(rst_n),
		.enable(idExEnable),
		.clear(idExClear),
		.d(decoded),
		.q(exStage)
	);

	executeUnit executeUnit_inst (
		.exStage(exStage),
		.fwdSelRs(fwdSelRs),
		.fwdSelRt(fwdSelRt),
		.memResult(memStage.result),
		.wbResult(wbStage.data),
		.executed(executed)
	);

	// Later stages never squash
	pipeStageReg #(.payloadT(exMemT)) exMemReg_inst (
		.clk(clk),
		.rst_n(rst_n),
		.enable(exMemEnable),
		.clear(1'b0),
		.d(executed),
		.q(memStage)
	);

	memoryUnit memoryUnit_inst (
		.memStage(memStage),
		.readData(readData),
		.dataReq(dataReq),
		.completed(completed)
	);

	pipeStageReg #(.payloadT(memWbT)) memWbReg_inst (
		.clk(clk),
		.rst_n(rst_n),
		.enable(memWbEnable),
		.clear(1'b0),
		.d(completed),
		.q(wbStage)
	);

	pipelineControl pipelineControl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.decodeInstr(decodeInstr),
		.exStage(exStage),
		.memStage(memStage),
		.wbStage(wbStage),
		.instrReq(instrReq),
		.instrReady(instrReady),
		.dataReq(dataReq),
		.dataReady(dataReady),
		.pcHold(pcHold),
		.ifIdHold(ifIdHold),
		.ifIdBubble(ifIdBubble),
		.idExEnable(idExEnable),
		.idExClear(idExClear),
		.exMemEnable(exMemEnable),
		.memWbEnable(memWbEnable),
		.fwdSelRs(fwdSelRs),
		.fwdSelRt(fwdSelRt),
		.halt(halt)
	);

endmodule

//--- source/decodeUnit.sv
// Decode stage with register file and writeback bypass
`include "core_params.svh"

module decodeUnit import isaPkg::*; import pipePkg::*; (
	input logic clk,
	input logic rst_n,
	input instrT decodeInstr,
	input memWbT wbStage,
	output idExT decoded
);

	wordT regFile [`CORE_REG_COUNT];

	// Same-cycle writeback goes straight through to the read port
	function automatic wordT bypassRead(regAddrT addr, wordT stored, memWbT wb);
		if (addr == '0) begin
			return '0;
		end
		if (wb.writeEn && wb.rd == addr) begin
			return wb.data;
		end
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbStage.writeEn && wbStage.rd != '0) begin
			regFile[wbStage.rd] <= wbStage.data;
		end
	end

	always_comb begin
		decoded = '0;
		decoded.opcode = decodeInstr.opcode;
		decoded.func = decodeInstr.low.r.func;
		decoded.rd = decodeInstr.rd;
		decoded.imm = {{(`CORE_XLEN - 16){decodeInstr.low.imm[15]}}, decodeInstr.low.imm};
		case (decodeInstr.opcode)
			OP_ALU: begin
				decoded.rs = decodeInstr.rs;
				decoded.rt = decodeInstr.low.r.rt;
				decoded.writeEn = decodeInstr.rd != '0;
			end
			OP_ADDI: begin
				decoded.rs = decodeInstr.rs;
				decoded.writeEn = decodeInstr.rd != '0;
			end
			OP_LOAD: begin
				decoded.rs = decodeInstr.rs;
				decoded.writeEn = decodeInstr.rd != '0;
				decoded.memRead = 1'b1;
			end
			OP_STORE: begin
				// Second read port fetches the store data register
				decoded.rs = decodeInstr.rs;
				decoded.rt = decodeInstr.rd;
				decoded.memWrite = 1'b1;
			end
			OP_HALT: decoded.halt = 1'b1;
			default: ;
		endcase
		decoded.rsValue = bypassRead(decoded.rs, regFile[decoded.rs], wbStage);
		decoded.rtValue = bypassRead(decoded.rt, regFile[decoded.rt], wbStage);
	end

endmodule

//--- source/executeUnit.sv
// Execute stage: operand forwarding, ALU and address generation
module executeUnit import isaPkg::*; import pipePkg::*; (
	input idExT exStage,
	input fwdSelT fwdSelRs,
	input fwdSelT fwdSelRt,
	input wordT memResult,
	input wordT wbResult,
	output exMemT executed
);

	wordT rsOperand;
	wordT rtOperand;
	wordT aluOut;

	function automatic wordT forwardMux(fwdSelT sel, wordT regValue, wordT memValue,
			wordT wbValue);
		case (sel)
			FWD_MEM: return memValue;
			FWD_WB: return wbValue;
			default: return regValue;
		endcase
	endfunction

	assign rsOperand = forwardMux(fwdSelRs, exStage.rsValue, memResult, wbResult);
	assign rtOperand = forwardMux(fwdSelRt, exStage.rtValue, memResult, wbResult);

	always_comb begin
		case (exStage.func)
			ALU_ADD: aluOut = rsOperand + rtOperand;
			ALU_SUB: aluOut = rsOperand - rtOperand;
			ALU_AND: aluOut = rsOperand & rtOperand;
			ALU_OR: aluOut = rsOperand | rtOperand;
			ALU_XOR: aluOut = rsOperand ^ rtOperand;
			ALU_SLT: aluOut = wordT'($signed(rsOperand) < $signed(rtOperand));
			default: aluOut = '0;
		endcase
	end

	// Immediate forms and memory addresses all use rs plus immediate
	always_comb begin
		executed.result = (exStage.opcode == OP_ALU) ? aluOut : rsOperand + exStage.imm;
		executed.storeData = rtOperand;
		executed.rd = exStage.rd;
		executed.writeEn = exStage.writeEn;
		executed.memRead = exStage.memRead;
		executed.memWrite = exStage.memWrite;
		executed.halt = exStage.halt;
	end

endmodule

//--- source/fetchUnit.sv
// Fetch stage with program counter, instruction-cache request and IF/ID register
`include "core_params.svh"

module fetchUnit import isaPkg::*; import pipePkg::*; (
	input logic clk,
	input logic rst_n,
	input logic pcHold,
	input logic ifIdHold,
	input logic ifIdBubble,
	input wordT instrData,
	input logic instrReady,
	output instrReqT instrReq,
	output instrT decodeInstr
);

	wordT pc;
	logic running;
	logic fetchDone;

	// No request until the first cycle out of reset
	assign instrReq.addr = pc;
	assign instrReq.valid = running && !ifIdBubble;
	assign fetchDone = instrReq.valid && instrReady;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `CORE_RESET_PC;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (fetchDone && !pcHold) begin
				pc <= pc + wordT'(`CORE_XLEN / 8);
			end
		end
	end

	// IF/ID takes a bubble when nothing was fetched
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			decodeInstr <= '0;
		end else if (!ifIdHold) begin
			if (fetchDone) begin
				decodeInstr <= instrT'(instrData);
			end else begin
				decodeInstr <= '0;
			end
		end
	end

endmodule

//--- source/isaPkg.sv
// Instruction set encodings and instruction field layout
`include "core_params.svh"

package isaPkg;

	typedef enum logic [`CORE_OPCODE_W-1:0] {
		OP_ALU = 6'h00,
		OP_ADDI = 6'h08,
		OP_LOAD = 6'h23,
		OP_STORE = 6'h2b,
		OP_HALT = 6'h3f
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,
		ALU_AND = 4'h2,
		ALU_OR = 4'h3,
		ALU_XOR = 4'h4,
		ALU_SLT = 4'h5
	} aluFuncT;

	// Register-register format of the low half
	typedef struct packed {
		logic [`CORE_REG_ADDR_W-1:0] rt;
		logic [6:0] pad;
		aluFuncT func;
	} regFieldsT;

	typedef union packed {
		regFieldsT r;
		logic [15:0] imm;
	} lowFieldsT;

	// For a store, rd names the data register
	typedef struct packed {
		opcodeT opcode;
		logic [`CORE_REG_ADDR_W-1:0] rd;
		logic [`CORE_REG_ADDR_W-1:0] rs;
		lowFieldsT low;
	} instrT;

endpackage

//--- source/memoryUnit.sv
// Memory stage: data-cache request and writeback data select
module memoryUnit import pipePkg::*; (
	input exMemT memStage,
	input wordT readData,
	output dataReqT dataReq,
	output memWbT completed
);

	logic isAccess;

	assign isAccess = memStage.memRead || memStage.memWrite;

	// Request held at a level until the cache raises ready
	assign dataReq.addr = memStage.result;
	assign dataReq.writeData = memStage.storeData;
	assign dataReq.write = memStage.memWrite;
	assign dataReq.valid = isAccess;

	// MEM/WB only loads on the cycle the cache answers, so load data lands there
	always_comb begin
		if (memStage.memRead) begin
			completed.data = readData;
		end else begin
			completed.data = memStage.result;
		end
		completed.rd = memStage.rd;
		completed.writeEn = memStage.writeEn;
		completed.halt = memStage.halt;
	end

endmodule

//--- source/pipePkg.sv
// Pipeline stage payloads and cache request types
`include "core_params.svh"

package pipePkg;
	import isaPkg::*;

	typedef logic [`CORE_REG_ADDR_W-1:0] regAddrT;
	typedef logic [`CORE_XLEN-1:0] wordT;

	// Decode to execute
	typedef struct packed {
		opcodeT opcode;
		aluFuncT func;
		regAddrT rd;
		regAddrT rs;
		regAddrT rt;
		wordT rsValue;
		wordT rtValue;
		wordT imm;
		logic writeEn;
		logic memRead;
		logic memWrite;
		logic halt;
	} idExT;

	// Execute to memory
	typedef struct packed {
		wordT result;
		wordT storeData;
		regAddrT rd;
		logic writeEn;
		logic memRead;
		logic memWrite;
		logic halt;
	} exMemT;

	// Memory to writeback
	typedef struct packed {
		wordT data;
		regAddrT rd;
		logic writeEn;
		logic halt;
	} memWbT;

	typedef struct packed {
		wordT addr;
		logic valid;
	} instrReqT;

	typedef struct packed {
		wordT addr;
		wordT writeData;
		logic write;
		logic valid;
	} dataReqT;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB = 2'd2
	} fwdSelT;

endpackage

//--- source/pipeStageReg.sv
// Pipeline stage register with hold and bubble insert for any payload type
module pipeStageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic clear,
	input payloadT d,
	output payloadT q
);

	// An all-zero payload is a bubble with every flag cleared
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end else if (enable) begin
			if (clear) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

//--- source/pipelineControl.sv
// Pipeline controller: stalls, squash, forwarding selects and halt state
module pipelineControl import isaPkg::*; import pipePkg::*; (
	input logic clk,
	input logic rst_n,
	input instrT decodeInstr,
	input idExT exStage,
	input exMemT memStage,
	input memWbT wbStage,
	input instrReqT instrReq,
	input logic instrReady,
	input dataReqT dataReq,
	input logic dataReady,
	output logic pcHold,
	output logic ifIdHold,
	output logic ifIdBubble,
	output logic idExEnable,
	output logic idExClear,
	output logic exMemEnable,
	output logic memWbEnable,
	output fwdSelT fwdSelRs,
	output fwdSelT fwdSelRt,
	output logic halt
);

	logic fullStall;
	logic loadUse;
	logic decodeHalt;
	logic haltPending;
	logic haltState;
	regAddrT idRs;
	regAddrT idRt;

	// Youngest writer wins
	function automatic fwdSelT pickSource(regAddrT src, exMemT mem, memWbT wb);
		if (src == '0) begin
			return FWD_REG;
		end
		if (mem.writeEn && mem.rd == src) begin
			return FWD_MEM;
		end
		if (wb.writeEn && wb.rd == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// Source registers actually read by the instruction in decode
	always_comb begin
		idRs = '0;
		idRt = '0;
		case (decodeInstr.opcode)
			OP_ALU: begin
				idRs = decodeInstr.rs;
				idRt = decodeInstr.low.r.rt;
			end
			OP_ADDI, OP_LOAD: idRs = decodeInstr.rs;
			OP_STORE: begin
				idRs = decodeInstr.rs;
				idRt = decodeInstr.rd;
			end
			default: ;
		endcase
	end

	assign fullStall = (instrReq.valid && !instrReady) || (dataReq.valid && !dataReady);
	assign loadUse = exStage.memRead && exStage.rd != '0
		&& (exStage.rd == idRs || exStage.rd == idRt);
	assign decodeHalt = decodeInstr.opcode == OP_HALT;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			haltPending <= 1'b0;
			haltState <= 1'b0;
		end else begin
			// Only once the halt has really left decode
			if (decodeHalt && !fullStall) begin
				haltPending <= 1'b1;
			end
			if (wbStage.halt) begin
				haltState <= 1'b1;
			end
		end
	end

	assign pcHold = fullStall || loadUse || haltPending;
	assign ifIdHold = fullStall || loadUse;
	assign ifIdBubble = haltPending;
	assign idExEnable = !fullStall;
	assign idExClear = loadUse || haltPending;
	assign exMemEnable = !fullStall;
	assign memWbEnable = !fullStall;

	always_comb begin
		fwdSelRs = pickSource(exStage.rs, memStage, wbStage);
		fwdSelRt = pickSource(exStage.rt, memStage, wbStage);
	end

	assign halt = haltState || wbStage.halt;

endmodule

//--- test/tbProgram.svh
// Random program builder and in-order reference model for the core testbench
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic int randomBelow(int limit);
	return int'({$random(seed)} % limit);
endfunction

function automatic wordT encodeAlu(aluFuncT func, regAddrT rd, regAddrT rs, regAddrT rt);
	return {OP_ALU, rd, rs, rt, 7'b0, func};
endfunction

function automatic wordT encodeImm(opcodeT op, regAddrT rd, regAddrT rs, logic [15:0] imm);
	return {op, rd, rs, imm};
endfunction

// Mode 0 chains results, mode 1 uses each load at once, mode 2 is a free mix
function automatic void buildProgram(int mode);
	regAddrT lastRd;
	regAddrT prevRd;
	regAddrT rd;
	regAddrT srcA;
	regAddrT srcB;
	logic [15:0] offset;
	int kind;
	lastRd = 5'd1;
	prevRd = 5'd2;
	for (int i = 0; i < PROG_LEN - 1; i++) begin
		case (mode)
			0: kind = (i % 4 == 3) ? 3 : i % 2;
			1: kind = (i % 3 == 0) ? 2 : ((i % 3 == 1) ? 1 : 3);
			default: kind = randomBelow(4);
		endcase
		rd = regAddrT'((mode == 2) ? randomBelow(8) : 1 + randomBelow(7));
		srcA = (mode == 2) ? regAddrT'(randomBelow(8)) : lastRd;
		srcB = (mode == 2) ? regAddrT'(randomBelow(8)) : prevRd;
		// Register 0 as base keeps every access inside the data array
		offset = 16'(randomBelow(DMEM_WORDS) * 4);
		case (kind)
			0: progWords[i] = encodeImm(OP_ADDI, rd, srcA, 16'(randomBelow(65536)));
			1: progWords[i] = encodeAlu(aluFuncT'(randomBelow(6)), rd, srcA, srcB);
			2: progWords[i] = encodeImm(OP_LOAD, rd, 5'd0, offset);
			default: progWords[i] = encodeImm(OP_STORE, srcA, 5'd0, offset);
		endcase
		if (kind != 3) begin
			prevRd = lastRd;
			lastRd = rd;
		end
	end
	for (int i = PROG_LEN - 1; i < IMEM_WORDS; i++) begin
		progWords[i] = encodeImm(OP_HALT, 5'd0, 5'd0, 16'h0);
	end
endfunction

// Runs the program in order and records each store and the final memory
function automatic void runReference();
	wordT regs [32];
	wordT w;
	wordT a;
	wordT b;
	wordT imm;
	wordT sum;
	wordT value;
	int pc;
	for (int i = 0; i < 32; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < DMEM_WORDS; i++) begin
		expMem[i] = initWord(i);
	end
	expStores.delete();
	pc = 0;
	while (progWords[pc][31:26] != OP_HALT) begin
		w = progWords[pc];
		a = regs[w[20:16]];
		b = regs[w[15:11]];
		imm = {{16{w[15]}}, w[15:0]};
		sum = a + imm;
		// Starts as the rd value, which a store writes out
		value = regs[w[25:21]];
		case (w[31:26])
			OP_ALU: begin
				case (w[3:0])
					ALU_ADD: value = a + b;
					ALU_SUB: value = a - b;
					ALU_AND: value = a & b;
					ALU_OR: value = a | b;
					ALU_XOR: value = a ^ b;
					ALU_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: value = '0;
				endcase
			end
			OP_ADDI: value = sum;
			OP_LOAD: value = expMem[sum[7:2]];
			OP_STORE: begin
				expStores.push_back('{addr: sum, writeData: value, write: 1'b1, valid: 1'b1});
				expMem[sum[7:2]] = value;
			end
			default: ;
		endcase
		regs[w[25:21]] = value;
		regs[0] = '0;
		pc++;
	end
endfunction

`endif

//--- test/cpuCoreTb.sv
// Testbench for the five-stage core with cache models and a reference model
module cpuCoreTb import isaPkg::*; import pipePkg::*; ();

	localparam int PROG_LEN = 24;
	localparam int FIXED_PROGS = 3;
	localparam int RANDOM_PROGS = 4;
	localparam int RESET_CYCLES = 10;
	localparam int SETTLE_CYCLES = 12;
	localparam int DMEM_WORDS = 64;
	localparam int IMEM_WORDS = 64;
	// Random ready phase gets four times the cycle budget
	localparam int WATCHDOG_CYCLES = 40 * PROG_LEN * (FIXED_PROGS + 4 * RANDOM_PROGS)
		+ (RESET_CYCLES + SETTLE_CYCLES) * (FIXED_PROGS + RANDOM_PROGS);

	logic clk;
	logic rst_n;
	wordT instrData;
	logic instrReady;
	wordT readData;
	logic dataReady;
	instrReqT instrReq;
	dataReqT dataReq;
	logic halt;

	integer seed;
	logic randomReady;
	wordT progWords [IMEM_WORDS];
	wordT dmem [DMEM_WORDS];
	wordT expMem [DMEM_WORDS];
	dataReqT expStores [$];
	dataReqT seenStores [$];
	logic sampled;
	logic sampledReset;
	logic sampledHalt;
	logic sampledValid;
	logic sampledDataValid;
	logic sampledDataWrite;
	logic haltLatched;
	int storeErrors;
	int haltErrors;
	int flagErrors;
	int memoryErrors;
	int otherErrors;

	// Mixes every address bit
	function automatic wordT initWord(int index);
		return wordT'(index) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f;
	endfunction

	`include "tbProgram.svh"

	cpuCore cpuCore_inst (
		.clk(clk),
		.rst_n(rst_n),
		.instrData(instrData),
		.instrReady(instrReady),
		.readData(readData),
		.dataReady(dataReady),
		.instrReq(instrReq),
		.dataReq(dataReq),
		.halt(halt)
	);

	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	task automatic checkStore(dataReqT got, dataReqT exp);
		if (got.addr !== exp.addr || got.writeData !== exp.writeData) begin
			storeErrors++;
			$display("FAILED at %0t: dataReq got addr %h data %h, expected addr %h data %h",
				$time, got.addr, got.writeData, exp.addr, exp.writeData);
		end
	endtask

	task automatic checkHalt(logic got, logic exp);
		if (got !== exp) begin
			haltErrors++;
			$display("FAILED at %0t: halt got %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			flagErrors++;
			$display("FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkWord(string name, wordT got, wordT exp);
		if (got !== exp) begin
			memoryErrors++;
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic printCounts();
		$display("Errors: store %0d, halt %0d, flag %0d, memory %0d, other %0d",
			storeErrors, haltErrors, flagErrors, memoryErrors, otherErrors);
	endtask

	// One clock of stimulus on the falling edge, with samples of the last rising edge
	task automatic runCycle(logic resetLevel);
		@(negedge clk);
		sampledReset = !rst_n;
		sampledHalt = halt;
		sampledValid = instrReq.valid;
		sampledDataValid = dataReq.valid;
		sampledDataWrite = dataReq.write;
		sampled = 1'b1;
		rst_n = resetLevel;
		instrReady = randomReady ? randomBelow(2) == 1 : 1'b1;
		dataReady = randomReady ? randomBelow(2) == 1 : 1'b1;
		instrData = progWords[instrReq.addr[7:2]];
		readData = dmem[dataReq.addr[7:2]];
		// A waiting fetch freezes MEM, so the same access is offered again
		if (resetLevel && dataReq.valid && dataReq.write && dataReady
				&& !(instrReq.valid && !instrReady)) begin
			seenStores.push_back(dataReq);
			dmem[dataReq.addr[7:2]] = dataReq.writeData;
		end
	endtask

	task automatic runProgram(int mode, logic randomPhase);
		buildProgram(mode);
		runReference();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = initWord(i);
		end
		randomReady = randomPhase;
		repeat (RESET_CYCLES) runCycle(1'b0);
		while (!sampledHalt) begin
			runCycle(1'b1);
		end
		repeat (SETTLE_CYCLES) runCycle(1'b1);
		if (expStores.size() != 0) begin
			otherErrors++;
			$display("Program mode %0d ended with %0d reference stores never seen on dataReq",
				mode, expStores.size());
			expStores.delete();
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			checkWord($sformatf("dmem[%0d]", i), dmem[i], expMem[i]);
		end
	endtask

	// Compares at the rising edge what the falling edge recorded
	always @(posedge clk) begin
		if (sampled) begin
			if (sampledReset) begin
				checkHalt(sampledHalt, 1'b0);
				checkFlag("instrReq.valid", sampledValid, 1'b0);
				checkFlag("dataReq.valid", sampledDataValid, 1'b0);
				checkFlag("dataReq.write", sampledDataWrite, 1'b0);
				haltLatched = 1'b0;
			end else begin
				if (haltLatched) begin
					checkHalt(sampledHalt, 1'b1);
				end
				if (sampledHalt) begin
					haltLatched = 1'b1;
					checkFlag("instrReq.valid", sampledValid, 1'b0);
				end
			end
			while (seenStores.size() > 0) begin
				if (expStores.size() == 0) begin
					otherErrors++;
					$display("Store to %h seen after the reference store list ran out",
						seenStores[0].addr);
					void'(seenStores.pop_front());
				end else begin
					checkStore(seenStores.pop_front(), expStores.pop_front());
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		otherErrors++;
		$display("Watchdog expired after %0d cycles before the last program halted",
			WATCHDOG_CYCLES);
		printCounts();
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		instrData = '0;
		instrReady = 1'b1;
		readData = '0;
		dataReady = 1'b1;
		seed = 32'h34bb7f90;
		randomReady = 1'b0;
		sampled = 1'b0;
		sampledHalt = 1'b0;
		haltLatched = 1'b0;
		storeErrors = 0;
		haltErrors = 0;
		flagErrors = 0;
		memoryErrors = 0;
		otherErrors = 0;
		for (int p = 0; p < FIXED_PROGS + RANDOM_PROGS; p++) begin
			runProgram(p % 3, p >= FIXED_PROGS);
		end
		repeat (2) runCycle(1'b1);
		printCounts();
		if (storeErrors + haltErrors + flagErrors + memoryErrors + otherErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
